//--- hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    // ************************************************************************
    // Architectural types and constants
    // ************************************************************************

    localparam int NUM_REGS = 32;          // x0 to x31.

    typedef logic [31:0] word_t;           // Data or instruction word.
    typedef logic [4:0]  reg_addr_t;       // Register index.

    // ************************************************************************
    // Major opcodes of the RV32I base set
    // ************************************************************************

    typedef enum logic [6:0] {
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111,
        OPC_JAL     = 7'b1101111,
        OPC_JALR    = 7'b1100111,
        OPC_BRANCH  = 7'b1100011,
        OPC_LOAD    = 7'b0000011,
        OPC_STORE   = 7'b0100011,
        OPC_ALU_IMM = 7'b0010011,
        OPC_ALU_REG = 7'b0110011
    } opcode_e;

    localparam logic [6:0] F7_BASE = 7'b0000000;  // Plain ALU and logical shift.
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA/SRAI.

    // Decoded operation class handed to execute.
    typedef enum logic [3:0] {
        OP_LUI,                            // Must stay first, reset value is 0.
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_ALU_IMM,
        OP_ALU_REG,
        OP_ILLEGAL
    } op_e;

endpackage

//--- hdl/op_classifier.sv
`timescale 1ns/1ns

module op_classifier
    import rv_decode_pkg::*;
(
    input  word_t inst,
    output op_e   op
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            OPC_LUI:   op = OP_LUI;
            OPC_AUIPC: op = OP_AUIPC;
            OPC_JAL:   op = OP_JAL;
            OPC_JALR: begin
                if (funct3 == 3'b000) op = OP_JALR;
            end
            OPC_BRANCH: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) op = OP_BRANCH;  // No 010/011 branch.
            end
            OPC_LOAD: begin
                if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
                    op = OP_LOAD;                      // LB, LH, LW, LBU, LHU.
                end
            end
            OPC_STORE: begin
                if (funct3 <= 3'b010) op = OP_STORE;   // SB, SH, SW.
            end
            OPC_ALU_IMM: begin
                if (funct3 == 3'b001) begin
                    if (funct7 == F7_BASE) op = OP_ALU_IMM;   // SLLI.
                end else if (funct3 == 3'b101) begin
                    if (funct7 == F7_BASE || funct7 == F7_ALT) op = OP_ALU_IMM;
                end else begin
                    op = OP_ALU_IMM;
                end
            end
            OPC_ALU_REG: begin
                if (funct7 == F7_BASE) begin
                    op = OP_ALU_REG;
                end else if (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    op = OP_ALU_REG;                   // SUB, SRA.
                end
            end
            default: op = OP_ILLEGAL;
        endcase
    end

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ns

module imm_gen
    import rv_decode_pkg::*;
(
    input  word_t inst,
    input  op_e   op,
    output word_t imm,
    output logic  reg_we
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // ************************************************************************
    // Immediate formats, all sign-extended from inst[31]
    // ************************************************************************

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (op)
            OP_JALR, OP_LOAD, OP_ALU_IMM: imm = imm_i;
            OP_STORE:                     imm = imm_s;
            OP_BRANCH:                    imm = imm_b;
            OP_LUI, OP_AUIPC:             imm = imm_u;
            OP_JAL:                       imm = imm_j;
            default:                      imm = '0;   // ALU_REG and ILLEGAL.
        endcase
    end

    always_comb begin
        case (op)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
            OP_LOAD, OP_ALU_IMM, OP_ALU_REG: reg_we = (inst[11:7] != 5'd0);
            default:                         reg_we = 1'b0;
        endcase
    end

endmodule

//--- hdl/operand_forward.sv
`timescale 1ns/1ns

module operand_forward
    import rv_decode_pkg::*;
(
    input  reg_addr_t src,
    input  logic      fwd1_we,
    input  reg_addr_t fwd1_rd,
    input  word_t     fwd1_data,
    input  logic      fwd2_we,
    input  reg_addr_t fwd2_rd,
    input  word_t     fwd2_data,
    input  logic      fwd3_we,
    input  reg_addr_t fwd3_rd,
    input  word_t     fwd3_data,
    input  word_t     rf_value,
    output word_t     value
);

    logic hit1;
    logic hit2;
    logic hit3;

    assign hit1 = fwd1_we && fwd1_rd != 5'd0 && fwd1_rd == src;
    assign hit2 = fwd2_we && fwd2_rd != 5'd0 && fwd2_rd == src;
    assign hit3 = fwd3_we && fwd3_rd != 5'd0 && fwd3_rd == src;

    // Youngest producer wins.
    assign value = hit1 ? fwd1_data :
                   hit2 ? fwd2_data :
                   hit3 ? fwd3_data :
                   rf_value;

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ns

module decoder
    import rv_decode_pkg::*;
(
    input  word_t     inst,
    input  logic      valid,
    input  logic      fwd1_we,
    input  reg_addr_t fwd1_rd,
    input  word_t     fwd1_data,
    input  logic      fwd2_we,
    input  reg_addr_t fwd2_rd,
    input  word_t     fwd2_data,
    input  logic      fwd3_we,
    input  reg_addr_t fwd3_rd,
    input  word_t     fwd3_data,
    input  word_t     rf_rs1_value,
    input  word_t     rf_rs2_value,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output op_e       op,
    output word_t     imm,
    output logic      reg_we,
    output word_t     rs1_value,
    output word_t     rs2_value
);

    logic fmt_reg_we;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    op_classifier op_classifier_i (.inst(inst), .op(op));

    imm_gen imm_gen_i (.inst(inst), .op(op), .imm(imm), .reg_we(fmt_reg_we));

    assign reg_we = fmt_reg_we & valid;           // Bubbles never write back.

    operand_forward rs1_forward_i (
        .src(rs1),
        .fwd1_we(fwd1_we), .fwd1_rd(fwd1_rd), .fwd1_data(fwd1_data),
        .fwd2_we(fwd2_we), .fwd2_rd(fwd2_rd), .fwd2_data(fwd2_data),
        .fwd3_we(fwd3_we), .fwd3_rd(fwd3_rd), .fwd3_data(fwd3_data),
        .rf_value(rf_rs1_value),
        .value(rs1_value)
    );

    operand_forward rs2_forward_i (
        .src(rs2),
        .fwd1_we(fwd1_we), .fwd1_rd(fwd1_rd), .fwd1_data(fwd1_data),
        .fwd2_we(fwd2_we), .fwd2_rd(fwd2_rd), .fwd2_data(fwd2_data),
        .fwd3_we(fwd3_we), .fwd3_rd(fwd3_rd), .fwd3_data(fwd3_data),
        .rf_value(rf_rs2_value),
        .value(rs2_value)
    );

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file
    import rv_decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_value,
    output word_t     rs2_value,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wdata
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is hardwired to zero.
    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      if_valid,
    input  word_t     if_inst,
    input  word_t     if_pc,
    input  logic      fwd1_we,
    input  reg_addr_t fwd1_rd,
    input  word_t     fwd1_data,
    input  logic      fwd2_we,
    input  reg_addr_t fwd2_rd,
    input  word_t     fwd2_data,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output logic      ex_valid,
    output op_e       ex_op,
    output word_t     ex_inst,
    output word_t     ex_pc,
    output word_t     ex_imm,
    output reg_addr_t ex_rs1,
    output reg_addr_t ex_rs2,
    output word_t     ex_rs1_value,
    output word_t     ex_rs2_value,
    output reg_addr_t ex_rd,
    output logic      ex_reg_we
);

    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    op_e       dec_op;
    word_t     dec_imm;
    logic      dec_reg_we;
    word_t     dec_rs1_value;
    word_t     dec_rs2_value;
    word_t     rf_rs1_value;
    word_t     rf_rs2_value;

    reg_file reg_file_i (
        .clk(clk), .rst_n(rst_n),
        .rs1(dec_rs1), .rs2(dec_rs2),
        .rs1_value(rf_rs1_value), .rs2_value(rf_rs2_value),
        .we(wb_we), .rd(wb_rd), .wdata(wb_data)
    );

    // Writeback doubles as the oldest forwarding source.
    decoder decoder_i (
        .inst(if_inst), .valid(if_valid),
        .fwd1_we(fwd1_we), .fwd1_rd(fwd1_rd), .fwd1_data(fwd1_data),
        .fwd2_we(fwd2_we), .fwd2_rd(fwd2_rd), .fwd2_data(fwd2_data),
        .fwd3_we(wb_we), .fwd3_rd(wb_rd), .fwd3_data(wb_data),
        .rf_rs1_value(rf_rs1_value), .rf_rs2_value(rf_rs2_value),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .op(dec_op), .imm(dec_imm), .reg_we(dec_reg_we),
        .rs1_value(dec_rs1_value), .rs2_value(dec_rs2_value)
    );

    // ************************************************************************
    // ID/EX pipeline register
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_op        <= OP_LUI;               // Encodes as zero.
            ex_inst      <= '0;
            ex_pc        <= '0;
            ex_imm       <= '0;
            ex_rs1       <= '0;
            ex_rs2       <= '0;
            ex_rs1_value <= '0;
            ex_rs2_value <= '0;
            ex_rd        <= '0;
            ex_reg_we    <= 1'b0;
        end else if (!stall) begin
            ex_valid     <= if_valid;
            ex_op        <= dec_op;
            ex_inst      <= if_inst;
            ex_pc        <= if_pc;
            ex_imm       <= dec_imm;
            ex_rs1       <= dec_rs1;
            ex_rs2       <= dec_rs2;
            ex_rs1_value <= dec_rs1_value;
            ex_rs2_value <= dec_rs2_value;
            ex_rd        <= dec_rd;
            ex_reg_we    <= dec_reg_we;           // Already low for bubbles.
        end
    end

endmodule

//--- verif/decode_stage_properties.sv
`timescale 1ns/1ns

module decode_stage_properties
    import rv_decode_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      stall,
    input logic      ex_valid,
    input op_e       ex_op,
    input word_t     ex_inst,
    input word_t     ex_pc,
    input word_t     ex_imm,
    input reg_addr_t ex_rs1,
    input reg_addr_t ex_rs2,
    input word_t     ex_rs1_value,
    input word_t     ex_rs2_value,
    input reg_addr_t ex_rd,
    input logic      ex_reg_we
);

    int failures = 0;

    valid_after_reset: assert property (@(posedge clk) !rst_n |=> !ex_valid)
        else begin
            $error("ex_valid high after reset");
            failures++;
        end

    // Every ID/EX field holds through a stalled cycle.
    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable({ex_valid, ex_op, ex_inst, ex_pc, ex_imm, ex_rs1, ex_rs2,
                           ex_rs1_value, ex_rs2_value, ex_rd, ex_reg_we}))
        else begin
            $error("ID/EX register changed during a stall");
            failures++;
        end

    write_needs_dest: assert property (@(posedge clk) disable iff (!rst_n)
        ex_reg_we |-> ex_valid && ex_rd != 5'd0)
        else begin
            $error("ex_reg_we without ex_valid or with ex_rd of zero");
            failures++;
        end

endmodule

bind decode_stage decode_stage_properties properties_i (.*);

//--- verif/decode_stage_tb.sv
`timescale 1ns/1ns

module decode_stage_tb
    import rv_decode_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_ROWS   = 18;
    localparam int MAX_CYCLES = NUM_ROWS * 4 + NUM_REGS + 2 + 4;  // Rows, preload, reset.

    localparam logic [1:0] SRC_RF  = 2'd0;
    localparam logic [1:0] SRC_F1  = 2'd1;
    localparam logic [1:0] SRC_F2  = 2'd2;
    localparam logic [1:0] SRC_WB  = 2'd3;

    typedef struct packed {
        word_t            inst;
        word_t            pc;
        logic             valid;
        logic             stall;
        logic [2:0]       fwd_we;                  // Index 0 is fwd1, 2 is writeback.
        logic [2:0][4:0]  fwd_rd;
        logic [2:0][31:0] fwd_data;
        op_e              op;
        word_t            imm;
        logic             reg_we;                  // Format rule only, before valid gating.
        logic [1:0]       src1;
        logic [1:0]       src2;
    } row_t;

    logic      clk;
    logic      rst_n = 1'b0;
    logic      stall = 1'b0;
    logic      if_valid = 1'b0;
    word_t     if_inst = '0;
    word_t     if_pc = '0;
    logic      fwd1_we = 1'b0;
    logic      fwd2_we = 1'b0;
    logic      wb_we = 1'b0;
    reg_addr_t fwd1_rd = '0;
    reg_addr_t fwd2_rd = '0;
    reg_addr_t wb_rd = '0;
    word_t     fwd1_data = '0;
    word_t     fwd2_data = '0;
    word_t     wb_data = '0;
    logic      ex_valid;
    logic      ex_reg_we;
    op_e       ex_op;
    word_t     ex_inst;
    word_t     ex_pc;
    word_t     ex_imm;
    word_t     ex_rs1_value;
    word_t     ex_rs2_value;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;

    row_t  rows [NUM_ROWS];
    word_t shadow [NUM_REGS] = '{default: '0};   // Mirror of the register file.
    int    n_rows = 0;

    decode_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic add_row(input word_t inst, input op_e op, input word_t imm, input logic we);
        row_t r;
        r        = '0;
        r.inst   = inst;
        r.pc     = 32'h0000_2000 + 32'(n_rows) * 32'd4;
        r.valid  = 1'b1;
        r.op     = op;
        r.imm    = imm;
        r.reg_we = we;
        for (int k = 0; k < 3; k++) begin
            r.fwd_data[k] = {4'hf, 4'(k), 24'(n_rows)};
        end
        rows[n_rows] = r;
        n_rows++;
    endtask

    // Forwarding setup of the last row and where each operand must come from.
    task automatic set_fwd(input logic [2:0] we, input reg_addr_t rd1, input reg_addr_t rd2,
                           input reg_addr_t rd3, input logic [1:0] s1, input logic [1:0] s2);
        rows[n_rows - 1].fwd_we = we;
        rows[n_rows - 1].fwd_rd = {rd3, rd2, rd1};
        rows[n_rows - 1].src1   = s1;
        rows[n_rows - 1].src2   = s2;
    endtask

    function automatic word_t operand(input row_t r, input logic [1:0] code, input reg_addr_t idx);
        if (code == SRC_RF) begin
            return shadow[idx];
        end
        return r.fwd_data[code - 2'd1];
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    initial begin
        row_t  r;
        row_t  last;
        word_t exp_rs1_value;
        word_t exp_rs2_value;
        word_t rng;

        // ********************************************************************
        // Stimulus table
        // ********************************************************************
        add_row({20'h12345, 5'd3, OPC_LUI}, OP_LUI, 32'h1234_5000, 1'b1);
        add_row({20'hfffff, 5'd4, OPC_AUIPC}, OP_AUIPC, 32'hffff_f000, 1'b1);
        add_row({1'b1, 10'h3fc, 1'b1, 8'hff, 5'd1, OPC_JAL}, OP_JAL, 32'hffff_fff8, 1'b1);
        add_row({12'h7ff, 5'd6, 3'b000, 5'd5, OPC_JALR}, OP_JALR, 32'h0000_07ff, 1'b1);
        add_row({1'b1, 6'h00, 5'd8, 5'd7, 3'b001, 4'b0010, 1'b1, OPC_BRANCH},
                OP_BRANCH, 32'hffff_f804, 1'b0);           // bne x7, x8, -2044
        add_row({12'hfff, 5'd12, 3'b010, 5'd11, OPC_LOAD}, OP_LOAD, 32'hffff_ffff, 1'b1);
        add_row({7'h4d, 5'd13, 5'd14, 3'b010, 5'h05, OPC_STORE}, OP_STORE, 32'hffff_f9a5, 1'b0);
        add_row({12'hf9c, 5'd16, 3'b000, 5'd15, OPC_ALU_IMM}, OP_ALU_IMM, 32'hffff_ff9c, 1'b1);
        add_row({F7_ALT, 5'd19, 5'd18, 3'b000, 5'd17, OPC_ALU_REG}, OP_ALU_REG, '0, 1'b1);
        add_row({F7_BASE, 5'd21, 5'd0, 3'b000, 5'd0, OPC_ALU_REG}, OP_ALU_REG, '0, 1'b0);
        add_row(32'h00a5_a07f, OP_ILLEGAL, '0, 1'b0);     // Unknown opcode.
        add_row({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, OPC_ALU_REG}, OP_ILLEGAL, '0, 1'b0);
        add_row({F7_BASE, 5'd5, 5'd5, 3'b000, 5'd22, OPC_ALU_REG}, OP_ALU_REG, '0, 1'b1);
        set_fwd(3'b111, 5'd5, 5'd5, 5'd5, SRC_F1, SRC_F1);
        add_row({F7_BASE, 5'd7, 5'd6, 3'b100, 5'd23, OPC_ALU_REG}, OP_ALU_REG, '0, 1'b1);
        set_fwd(3'b110, 5'd6, 5'd6, 5'd6, SRC_F2, SRC_RF);
        add_row({F7_BASE, 5'd8, 5'd0, 3'b110, 5'd24, OPC_ALU_REG}, OP_ALU_REG, '0, 1'b1);
        set_fwd(3'b101, 5'd0, 5'd8, 5'd8, SRC_RF, SRC_WB);
        add_row({20'hdead0, 5'd9, OPC_LUI}, OP_LUI, 32'hdead_0000, 1'b1);
        rows[n_rows - 1].stall = 1'b1;
        add_row({12'h005, 5'd8, 3'b000, 5'd25, OPC_ALU_IMM}, OP_ALU_IMM, 32'h0000_0005, 1'b1);
        add_row({F7_BASE, 5'd2, 5'd1, 3'b000, 5'd26, OPC_ALU_REG}, OP_ALU_REG, '0, 1'b1);
        rows[n_rows - 1].valid = 1'b0;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        rng = 32'hbbc;
        for (int i = 1; i < NUM_REGS; i++) begin
            rng = xorshift(rng);
            @(posedge clk);
            wb_we     <= 1'b1;
            wb_rd     <= 5'(i);
            wb_data   <= rng;
            shadow[i] = rng;
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rows[i];
            @(posedge clk);
            if_inst   <= r.inst;
            if_pc     <= r.pc;
            if_valid  <= r.valid;
            stall     <= r.stall;
            fwd1_we   <= r.fwd_we[0];
            fwd1_rd   <= r.fwd_rd[0];
            fwd1_data <= r.fwd_data[0];
            fwd2_we   <= r.fwd_we[1];
            fwd2_rd   <= r.fwd_rd[1];
            fwd2_data <= r.fwd_data[1];
            wb_we     <= r.fwd_we[2];
            wb_rd     <= r.fwd_rd[2];
            wb_data   <= r.fwd_data[2];
            if (!r.stall) begin                    // A stalled row keeps the old outputs.
                last          = r;
                exp_rs1_value = operand(r, r.src1, r.inst[19:15]);
                exp_rs2_value = operand(r, r.src2, r.inst[24:20]);
            end
            if (r.fwd_we[2] && r.fwd_rd[2] != 5'd0) begin
                shadow[r.fwd_rd[2]] = r.fwd_data[2];
            end
            @(posedge clk);
            @(negedge clk);
            check("ex_valid", 32'(ex_valid), 32'(last.valid));
            check("ex_op", 32'(ex_op), 32'(last.op));
            check("ex_inst", ex_inst, last.inst);
            check("ex_pc", ex_pc, last.pc);
            check("ex_imm", ex_imm, last.imm);
            check("ex_rs1", 32'(ex_rs1), 32'(last.inst[19:15]));
            check("ex_rs2", 32'(ex_rs2), 32'(last.inst[24:20]));
            check("ex_rd", 32'(ex_rd), 32'(last.inst[11:7]));
            check("ex_rs1_value", ex_rs1_value, exp_rs1_value);
            check("ex_rs2_value", ex_rs2_value, exp_rs2_value);
            check("ex_reg_we", 32'(ex_reg_we), 32'(last.reg_we & last.valid));
        end

        if (dut_i.properties_i.failures == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d assertion failures", dut_i.properties_i.failures);
            $display("Some tests failed");
            $fatal(1, "Assertion failures");
        end
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Simulation timed out after %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $fatal(1, "Timeout");
    end

endmodule

//--- verilog.f
hdl/rv_decode_pkg.sv
hdl/op_classifier.sv
hdl/imm_gen.sv
hdl/operand_forward.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/decode_stage.sv
verif/decode_stage_properties.sv
verif/decode_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The binary exits nonzero on $fatal, so make reports the failure.
sim: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
